// ==== filelist.f ====
+incdir+.
spi_pkg.sv
spi_sck_timer.sv
spi_xfer_fsm.sv
spi_shifter.sv
spi_master.sv
spi_slave_model.sv
spi_master_tb.sv

// ==== Bender.yml ====
package:
  name: spi_master

export_include_dirs:
  - .

sources:
  - spi_pkg.sv
  - spi_sck_timer.sv
  - spi_xfer_fsm.sv
  - spi_shifter.sv
  - spi_master.sv
  - target: simulation
    files:
      - spi_slave_model.sv
      - spi_master_tb.sv

// ==== spi_master_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_master_tb;

	localparam int NUM_ROWS      = 8;
	localparam int LATENCY       = 1 + (`SPI_WIDTH + 1) * 2 * `SPI_DIV;
	localparam int WAIT_LIMIT    = LATENCY + 8;
	localparam int TIMEOUT_LIMIT = NUM_ROWS * LATENCY + `SPI_TIMEOUT_MARGIN;

	logic                  CLK50MHZ;
	logic                  RST;
	logic                  start;
	logic                  miso;
	logic [`SPI_WIDTH-1:0] tx_data;
	logic [`SPI_WIDTH-1:0] rx_data;
	logic                  done;
	spi_pkg::spi_bus_t     spi_out;

	// Stimulus and expected values, one row per transfer
	logic [`SPI_WIDTH-1:0] row_tx      [NUM_ROWS];
	logic [`SPI_WIDTH-1:0] row_reply   [NUM_ROWS];
	logic                  row_restart [NUM_ROWS];

	int cycle_cnt     = 0;
	int done_total    = 0;
	int sck_violation = 0;
	int row_errs;
	int pass_count;
	int fail_count;

	spi_master DUT (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.start    (start),
		.miso     (miso),
		.tx_data  (tx_data),
		.rx_data  (rx_data),
		.done     (done),
		.spi_out  (spi_out)
	);

	spi_slave_model u_slave (
		.spi_in (spi_out),
		.miso   (miso)
	);

	initial begin
		CLK50MHZ = 1'b0;
	end

	always #10 CLK50MHZ = ~CLK50MHZ;

	////////////////////////////////////////////////////////////////////////////
	// Bus monitor and run limit
	////////////////////////////////////////////////////////////////////////////

	// Mid-cycle sampling, away from the DUT's register updates
	always @(negedge CLK50MHZ) begin
		if (!RST) begin
			if (done)
				done_total = done_total + 1;
			if (spi_out.sck && spi_out.cs_n)
				sck_violation = sck_violation + 1;
		end
	end

	always @(posedge CLK50MHZ) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_LIMIT) begin
			$display("Timeout: run exceeded %0d cycles", TIMEOUT_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [`SPI_WIDTH-1:0] random_word();
		logic [`SPI_WIDTH-1:0] word;
		int                    i;
		word = '0;
		for (i = 0; i < `SPI_WIDTH; i += 32)
			word = {word, $urandom};
		return word;
	endfunction

	// 1010... pattern with the MSB set for even widths
	function automatic logic [`SPI_WIDTH-1:0] alternating_word();
		logic [`SPI_WIDTH-1:0] word;
		int                    i;
		word = '0;
		for (i = 0; i < `SPI_WIDTH; i++)
			word[i] = (i % 2 == 1);
		return word;
	endfunction

	task automatic fill_table();
		int r;
		row_tx[0]      = '0;
		row_reply[0]   = {`SPI_WIDTH{1'b1}};
		row_restart[0] = 1'b0;
		row_tx[1]      = {`SPI_WIDTH{1'b1}};
		row_reply[1]   = '0;
		row_restart[1] = 1'b0;
		row_tx[2]      = alternating_word();
		row_reply[2]   = ~alternating_word();
		row_restart[2] = 1'b1;
		// Single bits at opposite ends catch order reversal
		row_tx[3]      = {{(`SPI_WIDTH-1){1'b0}}, 1'b1};
		row_reply[3]   = {1'b1, {(`SPI_WIDTH-1){1'b0}}};
		row_restart[3] = 1'b0;
		for (r = 4; r < NUM_ROWS; r++) begin
			row_tx[r]      = random_word();
			row_reply[r]   = random_word();
			row_restart[r] = (r % 2 == 1);
		end
	endtask

	task automatic check_idle_levels(input string where);
		if (spi_out.cs_n !== 1'b1) begin
			$display("Mismatch cs_n %s: expected 0x1, got 0x%h", where, spi_out.cs_n);
			row_errs++;
		end
		if (spi_out.sck !== 1'b0) begin
			$display("Mismatch sck %s: expected 0x0, got 0x%h", where, spi_out.sck);
			row_errs++;
		end
		if (spi_out.mosi !== 1'b0) begin
			$display("Mismatch mosi %s: expected 0x0, got 0x%h", where, spi_out.mosi);
			row_errs++;
		end
		if (done !== 1'b0) begin
			$display("Mismatch done %s: expected 0x0, got 0x%h", where, done);
			row_errs++;
		end
	endtask

	task automatic run_row(input int r);
		int done_before;
		int viol_before;
		int wait_cyc;
		bit got_done;
		done_before = done_total;
		viol_before = sck_violation;
		check_idle_levels("before transfer");
		u_slave.reply_word = row_reply[r];
		tx_data = row_tx[r];
		start   = 1'b1;
		wait_cyc = 0;
		got_done = 1'b0;
		while (!got_done && wait_cyc < WAIT_LIMIT) begin
			@(posedge CLK50MHZ);
			#2;
			start = 1'b0;
			wait_cyc++;
			if (done)
				got_done = 1'b1;
			else if (row_restart[r] && wait_cyc == LATENCY / 2)
				start = 1'b1;
		end
		if (!got_done) begin
			$display("Row %0d: no done pulse within %0d cycles of start", r, WAIT_LIMIT);
			row_errs++;
		end else begin
			if (rx_data !== row_reply[r]) begin
				$display("Mismatch rx_data: expected 0x%h, got 0x%h", row_reply[r], rx_data);
				row_errs++;
			end
			if (u_slave.captured !== row_tx[r]) begin
				$display("Mismatch captured: expected 0x%h, got 0x%h",
					row_tx[r], u_slave.captured);
				row_errs++;
			end
			if (u_slave.frame_edges != `SPI_WIDTH) begin
				$display("Mismatch frame_edges: expected 0x%h, got 0x%h",
					`SPI_WIDTH, u_slave.frame_edges);
				row_errs++;
			end
			if (spi_out.cs_n !== 1'b1) begin
				$display("Mismatch cs_n at done: expected 0x1, got 0x%h", spi_out.cs_n);
				row_errs++;
			end
		end
		// A few idle cycles so a stray or stretched done would show up
		repeat (3) begin
			@(posedge CLK50MHZ);
			#2;
		end
		if (done_total - done_before != 1) begin
			$display("Row %0d: done was high for %0d cycles instead of one",
				r, done_total - done_before);
			row_errs++;
		end
		if (sck_violation != viol_before) begin
			$display("Row %0d: SCK went high while chip select was inactive", r);
			row_errs++;
		end
		check_idle_levels("after transfer");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		RST        = 1'b1;
		start      = 1'b0;
		tx_data    = '0;
		pass_count = 0;
		fail_count = 0;
		void'($urandom(32'hc508));
		fill_table();

		repeat (8) @(posedge CLK50MHZ);
		#2;
		RST = 1'b0;
		@(posedge CLK50MHZ);
		#2;

		row_errs = 0;
		check_idle_levels("after reset");
		if (row_errs == 0) begin
			$display("Reset levels passed");
			pass_count++;
		end else begin
			$display("Reset levels failed");
			fail_count++;
		end

		for (int r = 0; r < NUM_ROWS; r++) begin
			row_errs = 0;
			run_row(r);
			if (row_errs == 0) begin
				$display("Row %0d passed, tx 0x%h reply 0x%h", r, row_tx[r], row_reply[r]);
				pass_count++;
			end else begin
				$display("Row %0d failed with %0d errors", r, row_errs);
				fail_count++;
			end
		end

		$display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== spi_slave_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_slave_model (
	input  spi_pkg::spi_bus_t spi_in,
	output logic              miso
);

	// Reply word is loaded by the testbench before each transfer
	logic [`SPI_WIDTH-1:0] reply_word = '0;
	logic [`SPI_WIDTH-1:0] captured   = '0;
	int                    bit_idx     = 0;
	int                    frame_edges = 0;

	logic sck;
	logic cs_n;

	assign sck  = spi_in.sck;
	assign cs_n = spi_in.cs_n;

	////////////////////////////////////////////////////////////////////////////
	// Frame tracking
	////////////////////////////////////////////////////////////////////////////

	// SCK is gated low outside the frame, so a rising cs_n never
	// coincides with a rising SCK
	always @(posedge sck or posedge cs_n) begin
		if (cs_n) begin
			// End of frame, keep the edge count for the testbench
			frame_edges <= bit_idx;
			bit_idx     <= 0;
		end else begin
			captured <= {captured[`SPI_WIDTH-2:0], spi_in.mosi};
			bit_idx  <= bit_idx + 1;
		end
	end

	// Top bit while cs_n is high, next bit after every rising SCK
	assign miso = (bit_idx < `SPI_WIDTH) ? reply_word[`SPI_WIDTH-1-bit_idx] : 1'b0;

endmodule

`default_nettype wire

// ==== spi_master.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_master (
	input  logic                  CLK50MHZ,
	input  logic                  RST,
	input  logic                  start,
	input  logic                  miso,
	input  logic [`SPI_WIDTH-1:0] tx_data,
	output logic [`SPI_WIDTH-1:0] rx_data,
	output logic                  done,
	output spi_pkg::spi_bus_t     spi_out
);

	spi_pkg::xfer_state_e state;
	logic                 sck_raw;
	logic                 bit_tick;
	logic                 cs_n;
	logic                 sck;
	logic                 mosi;

	////////////////////////////////////////////////////////////////////////////
	// SCK generation, sequencing and data path
	////////////////////////////////////////////////////////////////////////////

	spi_sck_timer u_sck_timer (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.state    (state),
		.sck_raw  (sck_raw),
		.bit_tick (bit_tick)
	);

	spi_xfer_fsm u_xfer_fsm (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.start    (start),
		.bit_tick (bit_tick),
		.sck_raw  (sck_raw),
		.state    (state),
		.cs_n     (cs_n),
		.sck      (sck),
		.done     (done)
	);

	spi_shifter u_shifter (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.bit_tick (bit_tick),
		.miso     (miso),
		.state    (state),
		.tx_data  (tx_data),
		.mosi     (mosi),
		.rx_data  (rx_data)
	);

	// Bus as seen by the slave
	assign spi_out = '{sck: sck, cs_n: cs_n, mosi: mosi};

endmodule

`default_nettype wire

// ==== spi_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_shifter (
	input  logic                  CLK50MHZ,
	input  logic                  RST,
	input  logic                  bit_tick,
	input  logic                  miso,
	input  spi_pkg::xfer_state_e  state,
	input  logic [`SPI_WIDTH-1:0] tx_data,
	output logic                  mosi,
	output logic [`SPI_WIDTH-1:0] rx_data
);

	// One guard bit below the word. The transfer runs one tick past
	// the last data bit, and that extra sample lands in the guard
	// bit instead of pushing the first received bit out the top.
	logic [`SPI_WIDTH:0] shift_reg;
	logic                shift_en;

	assign shift_en = (state == spi_pkg::SHIFT) && bit_tick;

	////////////////////////////////////////////////////////////////////////////
	// Data register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		case (state)
			spi_pkg::IDLE: begin
				// Track tx_data until the transfer begins
				shift_reg <= {tx_data, 1'b0};
			end
			spi_pkg::SHIFT: begin
				if (shift_en)
					shift_reg <= {shift_reg[`SPI_WIDTH-1:0], miso};
			end
			default: begin
				// DONE holds the received word
				shift_reg <= shift_reg;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// MOSI output
	////////////////////////////////////////////////////////////////////////////

	// Updated on the tick, so it changes with falling SCK and is stable
	// for the slave at the following rising edge
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			mosi <= 1'b0;
		end else begin
			case (state)
				spi_pkg::IDLE: begin
					mosi <= 1'b0;
				end
				spi_pkg::SHIFT: begin
					// Guard bit reaches the top on the closing tick,
					// which leaves MOSI low after the frame
					if (shift_en)
						mosi <= shift_reg[`SPI_WIDTH];
				end
				default: begin
					mosi <= mosi;
				end
			endcase
		end
	end

	// Received word sits above the guard bit
	assign rx_data = shift_reg[`SPI_WIDTH:1];

endmodule

`default_nettype wire

// ==== spi_xfer_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_xfer_fsm (
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	input  logic                 start,
	input  logic                 bit_tick,
	input  logic                 sck_raw,
	output spi_pkg::xfer_state_e state,
	output logic                 cs_n,
	output logic                 sck,
	output logic                 done
);

	localparam int WORD_BITS = `SPI_WIDTH;

	logic [`SPI_CNT_W-1:0] bit_cnt;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer and bit counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state   <= spi_pkg::IDLE;
			bit_cnt <= '0;
			cs_n    <= 1'b1;
		end else begin
			case (state)
				spi_pkg::IDLE: begin
					bit_cnt <= '0;
					cs_n    <= 1'b1;
					if (start)
						state <= spi_pkg::SHIFT;
				end
				spi_pkg::SHIFT: begin
					if (bit_tick) begin
						if (bit_cnt < WORD_BITS) begin
							// First tick also opens the frame
							cs_n    <= 1'b0;
							bit_cnt <= bit_cnt + 1'b1;
						end else begin
							// Closing tick, one past the last bit
							cs_n  <= 1'b1;
							state <= spi_pkg::DONE;
						end
					end
				end
				spi_pkg::DONE: begin
					state <= spi_pkg::IDLE;
				end
				default: begin
					state <= spi_pkg::IDLE;
				end
			endcase
		end
	end

	// SCK only reaches the pin inside the chip select frame
	assign sck  = cs_n ? 1'b0 : sck_raw;
	assign done = (state == spi_pkg::DONE);

endmodule

`default_nettype wire

// ==== spi_sck_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_sck_timer (
	input  logic                CLK50MHZ,
	input  logic                RST,
	input  spi_pkg::xfer_state_e state,
	output logic                sck_raw,
	output logic                bit_tick
);

	// One bit is enough when the divider is 1
	localparam int DIV_W    = (`SPI_DIV > 1) ? $clog2(`SPI_DIV) : 1;
	localparam int DIV_LAST = `SPI_DIV - 1;

	logic [DIV_W-1:0] half_cnt;
	logic             running;
	logic             half_wrap;

	assign running   = (state == spi_pkg::SHIFT);
	assign half_wrap = (half_cnt == DIV_LAST);

	// Held at zero outside SHIFT so every word starts with SCK low
	// and a full low half period ahead of the first edge
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !running) begin
			half_cnt <= '0;
			sck_raw  <= 1'b0;
		end else if (half_wrap) begin
			half_cnt <= '0;
			sck_raw  <= ~sck_raw;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// Last cycle of the high half, SCK falls on the next edge
	assign bit_tick = running && sck_raw && half_wrap;

endmodule

`default_nettype wire

// ==== spi_pkg.sv ====
`default_nettype none

package spi_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Transfer sequencing
	////////////////////////////////////////////////////////////////////////////

	// Shared by the FSM, the SCK timer and the shifter
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		SHIFT = 2'd1,
		DONE  = 2'd2
	} xfer_state_e;

	////////////////////////////////////////////////////////////////////////////
	// Master output bus
	////////////////////////////////////////////////////////////////////////////

	// SCK idles low, cs_n active low
	typedef struct packed {
		logic sck;
		logic cs_n;
		logic mosi;
	} spi_bus_t;

endpackage

`default_nettype wire

// ==== spi_consts.svh ====
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Transfer geometry
////////////////////////////////////////////////////////////////////////////

// Bits per transfer, MSB first
`define SPI_WIDTH 32

// System clocks per SCK half period
`define SPI_DIV 2

// Bit counter must reach SPI_WIDTH itself
`define SPI_CNT_W ($clog2(`SPI_WIDTH + 1))

// Extra cycles the testbench allows beyond the nominal run time
`define SPI_TIMEOUT_MARGIN 200

`endif
